// ==== hw/dpcIsaPkg.sv ====
`default_nettype none

package dpcIsaPkg;

    // Program word values 0 to 9, anything above reads as a nop
    typedef enum logic [3:0] {
        opNop       = 4'd0,
        opIncData   = 4'd1,
        opDecData   = 4'd2,
        opIncAp     = 4'd3,
        opDecAp     = 4'd4,
        opLoopOpen  = 4'd5,
        opLoopClose = 4'd6,
        opOut       = 4'd7,
        opIn        = 4'd8,
        opHalt      = 4'd9
    } dpcOpcodeE;

    typedef enum logic [2:0] {
        stIdle        = 3'd0,
        stFetch       = 3'd1,
        stExecute     = 3'd2,
        stSeekForward = 3'd3,
        stSeekBack    = 3'd4,
        stWaitIo      = 3'd5,
        stHalted      = 3'd6
    } dpcStateE;

endpackage

`default_nettype wire

// ==== hw/dpcMachinePkg.sv ====
`default_nettype none

package dpcMachinePkg;

    localparam int INSN_WIDTH   = 4;
    localparam int IP_WIDTH     = 6;    // 64 program words
    localparam int AP_WIDTH     = 5;    // 32 data cells
    localparam int DATA_DIGITS  = 3;
    localparam int DIGIT_WIDTH  = 4;
    localparam int DATA_WIDTH   = DATA_DIGITS * DIGIT_WIDTH;
    localparam int LOOP_WIDTH   = 4;
    localparam int OUT_CREDITS  = 2;    // Granted by the consumer at reset
    localparam int CREDIT_WIDTH = $clog2(OUT_CREDITS + 1);

endpackage

`default_nettype wire

// ==== hw/dpcInsnDecode.sv ====
`default_nettype none

module dpcInsnDecode
    import dpcIsaPkg::*;
    import dpcMachinePkg::*;
(
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  run,
    input  logic                  step,
    input  logic                  haltReq,
    input  logic                  progWe,
    input  logic [IP_WIDTH-1:0]   progAddr,
    input  logic [INSN_WIDTH-1:0] progInsn,
    input  logic                  insnDone,
    input  logic                  dataIsZero,
    output logic                  insnValid,
    output dpcOpcodeE             insnOp,
    output logic [IP_WIDTH-1:0]   ipAddress,
    output logic [LOOP_WIDTH-1:0] loopCount,
    output dpcStateE              dpcState
);

    logic [INSN_WIDTH-1:0] progMem [2**IP_WIDTH];
    dpcOpcodeE             memOp;       // Word under ip
    dpcOpcodeE             curOp;
    dpcOpcodeE             nestOp;
    dpcOpcodeE             matchOp;
    dpcStateE              stateNext;
    logic [IP_WIDTH-1:0]   ipNext;
    logic [LOOP_WIDTH-1:0] loopNext;
    logic                  stepMode;
    logic                  finish;
    logic                  fwd;
    logic                  seekEnd;
    logic                  outer;

    function automatic dpcOpcodeE decodeWord(input logic [INSN_WIDTH-1:0] word);
        if (word <= INSN_WIDTH'(opHalt)) begin
            return dpcOpcodeE'(word);
        end
        return opNop;
    endfunction

    always_ff @(posedge Clk) begin
        if (progWe && (dpcState == stIdle || dpcState == stHalted)) begin
            progMem[progAddr] <= progInsn;
        end
    end

    assign memOp     = decodeWord(progMem[ipAddress]);
    assign insnOp    = curOp;
    assign insnValid = (dpcState == stExecute) &&
                       (curOp inside {opIncData, opDecData, opIncAp, opDecAp, opOut, opIn});

    // Seek starts on the bracket itself with depth zero
    assign fwd     = dpcState == stSeekForward;
    assign nestOp  = fwd ? opLoopOpen : opLoopClose;
    assign matchOp = fwd ? opLoopClose : opLoopOpen;
    assign seekEnd = fwd ? (&ipAddress) : (ipAddress == '0);
    assign outer   = loopCount == LOOP_WIDTH'(1);

    always_comb begin
        stateNext = dpcState;
        ipNext    = ipAddress;
        loopNext  = loopCount;
        finish    = 1'b0;
        case (dpcState)
            stIdle: if (run || step) stateNext = stFetch;
            stHalted: begin
                if (run) begin
                    stateNext = stFetch;
                    ipNext    = '0;           // Restart from the first word
                end
            end
            stFetch: stateNext = haltReq ? stHalted : stExecute;
            stExecute: begin
                case (curOp)
                    opHalt:      stateNext = stHalted;
                    opNop:       finish = 1'b1;
                    opLoopOpen:  if (dataIsZero) stateNext = stSeekForward; else finish = 1'b1;
                    opLoopClose: if (!dataIsZero) stateNext = stSeekBack; else finish = 1'b1;
                    default:     if (insnDone) finish = 1'b1; else stateNext = stWaitIo;
                endcase
            end
            stWaitIo: finish = insnDone;
            stSeekForward, stSeekBack: begin
                if (memOp == matchOp && outer) begin
                    loopNext = '0;
                    finish   = 1'b1;           // Continue after the matching bracket
                end else begin
                    if (memOp == nestOp) begin
                        loopNext = loopCount + 1'b1;
                    end else if (memOp == matchOp) begin
                        loopNext = loopCount - 1'b1;
                    end
                    if (seekEnd) begin
                        stateNext = stHalted;  // Unmatched bracket
                        loopNext  = '0;
                    end else begin
                        ipNext = fwd ? ipAddress + 1'b1 : ipAddress - 1'b1;
                    end
                end
            end
            default: stateNext = stIdle;
        endcase
        if (finish) begin
            if (&ipAddress) begin
                stateNext = stHalted;          // Ran off the end of program memory
            end else begin
                ipNext    = ipAddress + 1'b1;
                stateNext = stepMode ? stIdle : stFetch;
            end
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            dpcState  <= stIdle;
            ipAddress <= '0;
            loopCount <= '0;
            curOp     <= opNop;
            stepMode  <= 1'b0;
        end else begin
            dpcState  <= stateNext;
            ipAddress <= ipNext;
            loopCount <= loopNext;
            if (dpcState == stFetch) begin
                curOp <= memOp;
            end
            if (dpcState == stIdle && (run || step)) begin
                stepMode <= !run;
            end else if (dpcState == stHalted && run) begin
                stepMode <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/dpcDataExecute.sv ====
`default_nettype none

module dpcDataExecute
    import dpcIsaPkg::*;
    import dpcMachinePkg::*;
(
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  insnValid,
    input  dpcOpcodeE             insnOp,
    input  logic                  ioDone,
    input  logic [DATA_WIDTH-1:0] ioInData,
    output logic                  insnDone,
    output logic                  dataIsZero,
    output logic [AP_WIDTH-1:0]   apAddress,
    output logic                  ioOutStart,
    output logic                  ioInStart,
    output logic [DATA_WIDTH-1:0] ioOutData
);

    logic [DATA_WIDTH-1:0] cells [2**AP_WIDTH];
    logic [DATA_WIDTH-1:0] curCell;
    logic                  ioBusy;
    logic                  ioIsIn;
    logic                  isIo;

    // Dekatron style count, wraps 999 to 000 and back
    function automatic logic [DATA_WIDTH-1:0] bcdStep(input logic [DATA_WIDTH-1:0] value,
                                                      input logic down);
        logic [DATA_WIDTH-1:0]  result;
        logic [DIGIT_WIDTH-1:0] digit;
        logic                   carry;
        result = value;
        carry  = 1'b1;
        for (int i = 0; i < DATA_DIGITS; i++) begin
            digit = value[i*DIGIT_WIDTH +: DIGIT_WIDTH];
            if (carry) begin
                if (down) begin
                    carry = digit == '0;
                    digit = carry ? DIGIT_WIDTH'(9) : digit - 1'b1;
                end else begin
                    carry = digit == DIGIT_WIDTH'(9);
                    digit = carry ? '0 : digit + 1'b1;
                end
            end
            result[i*DIGIT_WIDTH +: DIGIT_WIDTH] = digit;
        end
        return result;
    endfunction

    assign curCell    = cells[apAddress];
    assign dataIsZero = curCell == '0;
    assign ioOutData  = curCell;
    assign isIo       = insnOp inside {opOut, opIn};
    assign ioOutStart = insnValid && insnOp == opOut;
    assign ioInStart  = insnValid && insnOp == opIn;
    assign insnDone   = (insnValid && !isIo) || (ioBusy && ioDone);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            apAddress <= '0;
            ioBusy    <= 1'b0;
            ioIsIn    <= 1'b0;
            for (int i = 0; i < 2**AP_WIDTH; i++) begin
                cells[i] <= '0;
            end
        end else begin
            if (insnValid) begin
                case (insnOp)
                    opIncData: cells[apAddress] <= bcdStep(curCell, 1'b0);
                    opDecData: cells[apAddress] <= bcdStep(curCell, 1'b1);
                    opIncAp:   apAddress <= apAddress + 1'b1;     // Wraps modulo 32
                    opDecAp:   apAddress <= apAddress - 1'b1;
                    opOut, opIn: begin
                        ioBusy <= 1'b1;
                        ioIsIn <= insnOp == opIn;
                    end
                    default: ;
                endcase
            end
            if (ioBusy && ioDone) begin
                ioBusy <= 1'b0;
                if (ioIsIn) begin
                    cells[apAddress] <= ioInData;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/dpcIoResult.sv ====
`default_nettype none

module dpcIoResult
    import dpcMachinePkg::*;
(
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  ioOutStart,
    input  logic [DATA_WIDTH-1:0] ioOutData,
    input  logic                  ioInStart,
    input  logic                  coutCredit,
    input  logic                  cinAck,
    input  logic [DATA_WIDTH-1:0] cinData,
    output logic                  ioDone,
    output logic [DATA_WIDTH-1:0] ioInData,
    output logic                  coutValid,
    output logic [DATA_WIDTH-1:0] coutData,
    output logic                  cinReq
);

    logic [CREDIT_WIDTH-1:0] credits;
    logic [DATA_WIDTH-1:0]   outBuf;
    logic                    outPending;
    logic                    sendNow;
    logic                    creditBack;
    logic                    inTaken;

    assign sendNow    = outPending && credits != '0;
    assign inTaken    = cinReq && cinAck;
    // Extra returns at full count are dropped
    assign creditBack = coutCredit && (credits != CREDIT_WIDTH'(OUT_CREDITS) || sendNow);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            credits    <= CREDIT_WIDTH'(OUT_CREDITS);
            outPending <= 1'b0;
            coutValid  <= 1'b0;
            cinReq     <= 1'b0;
            ioDone     <= 1'b0;
        end else begin
            coutValid <= sendNow;
            ioDone    <= sendNow || inTaken;
            credits   <= credits - CREDIT_WIDTH'(sendNow) + CREDIT_WIDTH'(creditBack);
            if (ioOutStart) begin
                outPending <= 1'b1;
            end else if (sendNow) begin
                outPending <= 1'b0;
            end
            if (ioInStart) begin
                cinReq <= 1'b1;
            end else if (inTaken) begin
                cinReq <= 1'b0;                 // Drops the cycle after the ack
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (ioOutStart) begin
            outBuf <= ioOutData;
        end
        if (sendNow) begin
            coutData <= outBuf;
        end
        if (inTaken) begin
            ioInData <= cinData;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dekatronCore.sv ====
`default_nettype none

module dekatronCore
    import dpcIsaPkg::*;
    import dpcMachinePkg::*;
(
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  run,
    input  logic                  step,
    input  logic                  haltReq,
    input  logic                  progWe,
    input  logic [IP_WIDTH-1:0]   progAddr,
    input  logic [INSN_WIDTH-1:0] progInsn,
    output logic                  coutValid,
    output logic [DATA_WIDTH-1:0] coutData,
    input  logic                  coutCredit,
    output logic                  cinReq,
    input  logic                  cinAck,
    input  logic [DATA_WIDTH-1:0] cinData,
    output logic [IP_WIDTH-1:0]   ipAddress,
    output logic [AP_WIDTH-1:0]   apAddress,
    output logic [LOOP_WIDTH-1:0] loopCount,
    output dpcStateE              dpcState
);

    logic                  insnValid;
    dpcOpcodeE             insnOp;
    logic                  insnDone;
    logic                  dataIsZero;
    logic                  ioOutStart;
    logic                  ioInStart;
    logic [DATA_WIDTH-1:0] ioOutData;
    logic                  ioDone;
    logic [DATA_WIDTH-1:0] ioInData;

    dpcInsnDecode i_decode (
        .Clk        (Clk),
        .rstN       (rstN),
        .run        (run),
        .step       (step),
        .haltReq    (haltReq),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progInsn   (progInsn),
        .insnDone   (insnDone),
        .dataIsZero (dataIsZero),
        .insnValid  (insnValid),
        .insnOp     (insnOp),
        .ipAddress  (ipAddress),
        .loopCount  (loopCount),
        .dpcState   (dpcState)
    );

    dpcDataExecute i_execute (
        .Clk        (Clk),
        .rstN       (rstN),
        .insnValid  (insnValid),
        .insnOp     (insnOp),
        .ioDone     (ioDone),
        .ioInData   (ioInData),
        .insnDone   (insnDone),
        .dataIsZero (dataIsZero),
        .apAddress  (apAddress),
        .ioOutStart (ioOutStart),
        .ioInStart  (ioInStart),
        .ioOutData  (ioOutData)
    );

    dpcIoResult i_result (
        .Clk        (Clk),
        .rstN       (rstN),
        .ioOutStart (ioOutStart),
        .ioOutData  (ioOutData),
        .ioInStart  (ioInStart),
        .coutCredit (coutCredit),
        .cinAck     (cinAck),
        .cinData    (cinData),
        .ioDone     (ioDone),
        .ioInData   (ioInData),
        .coutValid  (coutValid),
        .coutData   (coutData),
        .cinReq     (cinReq)
    );

endmodule

`default_nettype wire

// ==== dv/dekatronCore_sva.sv ====
`default_nettype none

module dekatronCoreSva
    import dpcIsaPkg::*;
    import dpcMachinePkg::*;
(
    input logic                  Clk,
    input logic                  rstN,
    input logic                  coutValid,
    input logic                  coutCredit,
    input logic                  cinReq,
    input logic                  cinAck,
    input logic [DATA_WIDTH-1:0] cellValue,
    input logic [LOOP_WIDTH-1:0] loopCount,
    input dpcStateE              dpcState
);
    timeunit 1ns;
    timeprecision 1ps;

    int outstanding;    // Words sent and not yet paid back by the consumer

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(coutValid) - int'(coutCredit);
        end
    end

    // Sends never run ahead of the credits returned on the channel
    noSendWithoutCredit: assert property (@(posedge Clk) disable iff (!rstN)
        coutValid |-> outstanding < OUT_CREDITS)
        else $error("coutValid seen with no output credit available");

    cinReqHeld: assert property (@(posedge Clk) disable iff (!rstN)
        cinReq && !cinAck |=> cinReq)
        else $error("cinReq dropped before cinAck");

    loopIdleInFetch: assert property (@(posedge Clk) disable iff (!rstN)
        dpcState == stFetch |-> loopCount == '0)
        else $error("loopCount not zero in fetch");

    cellDigitsDecimal: assert property (@(posedge Clk) disable iff (!rstN)
        cellValue[3:0] <= 4'd9 && cellValue[7:4] <= 4'd9 && cellValue[11:8] <= 4'd9)
        else $error("Cell digit above 9");

endmodule

bind dekatronCore dekatronCoreSva i_sva (
    .Clk        (Clk),
    .rstN       (rstN),
    .coutValid  (coutValid),
    .coutCredit (coutCredit),
    .cinReq     (cinReq),
    .cinAck     (cinAck),
    .cellValue  (i_execute.ioOutData),
    .loopCount  (loopCount),
    .dpcState   (dpcState)
);

`default_nettype wire

// ==== dv/dekatronCoreTb.sv ====
`default_nettype none

module dekatronCoreTb
    import dpcIsaPkg::*;
    import dpcMachinePkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 11;     // Programs run over all tests
    localparam int MAX_CYCLES = 2000;   // Longest program is the nested multiply

    logic                  Clk = 1'b0;
    logic                  rstN;
    logic                  run;
    logic                  step;
    logic                  haltReq;
    logic                  progWe;
    logic [IP_WIDTH-1:0]   progAddr;
    logic [INSN_WIDTH-1:0] progInsn;
    logic                  coutValid;
    logic [DATA_WIDTH-1:0] coutData;
    logic                  coutCredit;
    logic                  cinReq;
    logic                  cinAck;
    logic [DATA_WIDTH-1:0] cinData;
    logic [IP_WIDTH-1:0]   ipAddress;
    logic [AP_WIDTH-1:0]   apAddress;
    logic [LOOP_WIDTH-1:0] loopCount;
    dpcStateE              dpcState;

    dpcOpcodeE   prog[$];
    int          expOut[$];
    int          gotOut[$];
    int          inVals[$];
    int          inIdx;
    int          owedCredits;
    bit          holdCredits;
    int          expIp;
    int          expAp;
    int          errCount = 0;
    logic [15:0] lfsrState = 16'd76;

    dekatronCore i_dut (.*);

    initial begin
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    initial begin
        #(NUM_TESTS * (MAX_CYCLES + 100) * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("TB FAILED");
        $fatal(1, "watchdog");
    end

    function automatic logic stepLfsr();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) lfsrState = lfsrState ^ 16'hB400;
        return outBit;
    endfunction

    function automatic int lfsrBits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) v = (v << 1) | int'(stepLfsr());
        return v;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] toBcd(int v);
        return {DIGIT_WIDTH'(v / 100), DIGIT_WIDTH'(v / 10 % 10), DIGIT_WIDTH'(v % 10)};
    endfunction

    task automatic checkEq(int got, int exp, string what);
        if (got !== exp) begin
            errCount++;
            $display("ERROR @%0t: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic abortRun(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, why);
    endtask

    task automatic waitState(dpcStateE st, string what);
        int n;
        n = 0;
        while (dpcState != st) begin
            if (n >= MAX_CYCLES) abortRun({"Timed out waiting for ", what});
            else begin
                @(negedge Clk);
                n++;
            end
        end
    endtask

    // Consumer returns one credit per cycle unless told to hold them
    always @(negedge Clk) begin
        coutCredit = 1'b0;
        if (coutValid) begin
            gotOut.push_back(int'(coutData));
            owedCredits++;
        end
        if (owedCredits > 0 && !holdCredits) begin
            coutCredit = 1'b1;
            owedCredits--;
        end
    end

    always begin
        @(negedge Clk);
        cinAck = 1'b0;
        if (cinReq) begin
            repeat (lfsrBits(3)) @(negedge Clk);
            if (inIdx >= inVals.size()) abortRun("Core asked for input with none left");
            else begin
                cinData = toBcd(inVals[inIdx]);
                inIdx++;
                cinAck  = 1'b1;
            end
        end
    end

    task automatic applyReset();
        rstN    = 1'b0;
        run     = 1'b0;
        step    = 1'b0;
        haltReq = 1'b0;
        progWe  = 1'b0;
        repeat (4) @(negedge Clk);
        rstN        = 1'b1;
        owedCredits = 0;
        inIdx       = 0;
        gotOut.delete();
        @(negedge Clk);
    endtask

    task automatic loadProgram(string src);
        prog.delete();
        for (int i = 0; i < src.len(); i++) begin
            case (src[i])
                "+":     prog.push_back(opIncData);
                "-":     prog.push_back(opDecData);
                ">":     prog.push_back(opIncAp);
                "<":     prog.push_back(opDecAp);
                "[":     prog.push_back(opLoopOpen);
                "]":     prog.push_back(opLoopClose);
                ".":     prog.push_back(opOut);
                ",":     prog.push_back(opIn);
                default: prog.push_back(opHalt);    // H
            endcase
        end
        prog.push_back(opHalt);
        foreach (prog[i]) begin
            progWe   = 1'b1;
            progAddr = IP_WIDTH'(i);
            progInsn = prog[i];
            @(negedge Clk);
        end
        progWe = 1'b0;
    endtask

    // Tape interpreter with three digit decimal cells
    task automatic runModel();
        int cells [2**AP_WIDTH];
        int ap;
        int ip;
        int depth;
        int inPos;
        foreach (cells[i]) cells[i] = 0;
        expOut.delete();
        ap    = 0;
        ip    = 0;
        inPos = 0;
        while (ip < prog.size() && prog[ip] != opHalt) begin
            case (prog[ip])
                opIncData: cells[ap] = (cells[ap] + 1) % 1000;
                opDecData: cells[ap] = (cells[ap] + 999) % 1000;
                opIncAp:   ap = (ap + 1) % 2**AP_WIDTH;
                opDecAp:   ap = (ap + 2**AP_WIDTH - 1) % 2**AP_WIDTH;
                opOut:     expOut.push_back(cells[ap]);
                opIn: begin
                    cells[ap] = inVals[inPos];
                    inPos++;
                end
                opLoopOpen: begin
                    depth = cells[ap] == 0 ? 1 : 0;
                    while (depth > 0) begin
                        ip++;
                        if (prog[ip] == opLoopOpen) depth++;
                        else if (prog[ip] == opLoopClose) depth--;
                    end
                end
                opLoopClose: begin
                    depth = cells[ap] != 0 ? 1 : 0;
                    while (depth > 0) begin
                        ip--;
                        if (prog[ip] == opLoopClose) depth++;
                        else if (prog[ip] == opLoopOpen) depth--;
                    end
                end
                default: ;
            endcase
            ip++;
        end
        expIp = ip;
        expAp = ap;
    endtask

    task automatic startProgram(string src);
        applyReset();
        loadProgram(src);
        runModel();
        run = 1'b1;
        @(negedge Clk);
        run = 1'b0;
    endtask

    task automatic finishProgram();
        waitState(stHalted, "program halt");
        repeat (2) @(negedge Clk);
        checkEq(gotOut.size(), expOut.size(), "number of output words");
        foreach (expOut[i]) begin
            checkEq(gotOut[i], int'(toBcd(expOut[i])), "output word");
        end
        checkEq(int'(ipAddress), expIp, "ipAddress at halt");
        checkEq(int'(apAddress), expAp, "apAddress at halt");
    endtask

    task automatic stepOnce();
        step = 1'b1;
        @(negedge Clk);
        step = 1'b0;
        waitState(stIdle, "single step");
    endtask

    task automatic decimalCounting();
        startProgram("++++++++++++.");
        finishProgram();
        checkEq(gotOut[0], 'h012, "twelve increments");
        startProgram("-.+.");
        finishProgram();
        checkEq(gotOut[0], 'h999, "decrement below zero");
        checkEq(gotOut[1], 'h000, "increment above 999");
    endtask

    task automatic pointerMoves();
        startProgram("+++>+++++>++<<.>.>.<<<+.");
        finishProgram();
        checkEq(int'(apAddress), 2**AP_WIDTH - 1, "pointer left of cell 0");
    endtask

    task automatic loopPrograms();
        startProgram("+++++[-].");
        finishProgram();
        startProgram("+++[>++++[>+++++<-]<-]>>.");
        finishProgram();
        startProgram("[+++.]++.");
        finishProgram();
    endtask

    task automatic outputBackPressure();
        int n;
        holdCredits = 1'b1;
        startProgram("+.+.+.+.+.");
        n = 0;
        while (gotOut.size() < OUT_CREDITS && n < MAX_CYCLES) begin
            @(negedge Clk);
            n++;
        end
        repeat (20) @(negedge Clk);     // Stalled core must not move on
        checkEq(gotOut.size(), OUT_CREDITS, "words sent while out of credit");
        checkEq(int'(dpcState), int'(stWaitIo), "state while out of credit");
        holdCredits = 1'b0;
        finishProgram();
    endtask

    task automatic inputEcho();
        inVals.delete();
        repeat (4) inVals.push_back(lfsrBits(10) % 1000);
        startProgram(",.>,.>,.>,.");
        finishProgram();
        foreach (inVals[i]) begin
            checkEq(gotOut[i], int'(toBcd(inVals[i])), "echoed input");
        end
        inVals.delete();
    endtask

    task automatic stepAndHalt();
        applyReset();
        loadProgram("+>+");
        stepOnce();
        checkEq(int'(ipAddress), 1, "ipAddress after first step");
        stepOnce();
        checkEq(int'(ipAddress), 2, "ipAddress after second step");
        checkEq(int'(apAddress), 1, "apAddress after second step");
        startProgram("-[-]");           // Nearly a thousand passes
        repeat (200) @(negedge Clk);
        haltReq = 1'b1;
        waitState(stHalted, "halt request");
        haltReq = 1'b0;
        checkEq(int'(loopCount), 0, "loopCount after halt request");
        startProgram("+>+H++");
        finishProgram();
        checkEq(int'(ipAddress), 3, "ipAddress on halt word");
    endtask

    initial begin
        rstN        = 1'b0;
        run         = 1'b0;
        step        = 1'b0;
        haltReq     = 1'b0;
        progWe      = 1'b0;
        progAddr    = '0;
        progInsn    = '0;
        coutCredit  = 1'b0;
        cinAck      = 1'b0;
        cinData     = '0;
        holdCredits = 1'b0;
        decimalCounting();
        pointerMoves();
        loopPrograms();
        outputBackPressure();
        inputEcho();
        stepAndHalt();
        if (errCount == 0) $display("TB PASSED");
        else $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/dpcIsaPkg.sv
hw/dpcMachinePkg.sv
hw/dpcInsnDecode.sv
hw/dpcDataExecute.sv
hw/dpcIoResult.sv
hw/dekatronCore.sv
dv/dekatronCore_sva.sv
dv/dekatronCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dekatronCoreTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
